// ==== sources.f ====
verilog/sema_pkg.sv
verilog/sema_ack_gen.sv
verilog/sema_key_ram.sv
verilog/sema_config.sv
verilog/sema_mem.sv
verilog/sema_top.sv
tb/sema_properties.sv
tb/sema_checker.sv
tb/sema_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the semaphore bank testbench with Verilator.
# Exit status is nonzero when the log shows a failure or no final result.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module sema_tb -f sources.f -o sema_sim \
	|| { echo "build failed"; exit 1; }

./obj_dir/sema_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

grep -q "SOME TESTS FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"

// ==== tb/sema_tb.sv ====
// top-level testbench for the semaphore bank
// 64 slots of 16-bit keys, BAR0 starts at IO_ADDR
// one access at a time, held through the ack cycle, then one idle cycle
// read data and latency checks live in sema_checker
`timescale 1ns/1ps

module sema_tb import sema_pkg::*; ();

	localparam int          NUM_SEMA = 64;
	localparam int          KEY_SIZE = 16;
	localparam word_t       IO_ADDR = 32'hFEE80001;
	localparam word_t       IO_ADDR_MASK = 32'h00FC0000;
	localparam logic [7:0]  CFG_BUS = 8'd0;
	localparam logic [4:0]  CFG_DEVICE = 5'd17;
	localparam logic [2:0]  CFG_FUNC = 3'd0;
	localparam logic [15:0] VENDOR_ID = 16'h1A2B;
	localparam logic [15:0] DEVICE_ID = 16'h0017;
	localparam logic [7:0]  CLASS_CODE = 8'h05;
	localparam logic [7:0]  SUBCLASS = 8'h80;
	localparam logic [7:0]  PROGIF = 8'h01;
	localparam logic [7:0]  REVISION = 8'h03;
	localparam int          ACK_TIMEOUT = 20;
	localparam int          RANDOM_OPS = 300;

	logic clk = 1'b0;
	logic reset;
	bus_req_t req;
	logic cs_config;
	logic cs_io;
	logic ack;
	word_t dat;
	word_t cfg_exp;
	// masked BAR0, base of the open semaphore window
	word_t sema_base;
	// keep the strobe up through the blanking cycle after ack
	logic hold_blank;
	int bus_errors = 0;
	int chk_errors;

	// 8 ns period
	always #4 clk = ~clk;

	sema_top #(
		.NUM_SEMAPHORE(NUM_SEMA), .KEY_SIZE(KEY_SIZE),
		.IO_ADDR(IO_ADDR), .IO_ADDR_MASK(IO_ADDR_MASK),
		.CFG_BUS(CFG_BUS), .CFG_DEVICE(CFG_DEVICE), .CFG_FUNC(CFG_FUNC),
		.CFG_VENDOR_ID(VENDOR_ID), .CFG_DEVICE_ID(DEVICE_ID),
		.CFG_CLASS(CLASS_CODE), .CFG_SUBCLASS(SUBCLASS), .CFG_REVISION_ID(REVISION)
	) dut_i (
		.clk_i(clk), .reset_i(reset), .cs_config_i(cs_config), .cs_io_i(cs_io),
		.req_i(req), .ack_o(ack), .dat_o(dat)
	);

	sema_checker #(.NUM_SEMAPHORE(NUM_SEMA), .KEY_SIZE(KEY_SIZE)) u_checker (
		.clk_i(clk), .reset_i(reset), .req_i(req), .cs_config_i(cs_config), .cs_io_i(cs_io),
		.ack_i(ack), .dat_i(dat), .cfg_exp_i(cfg_exp), .err_count_o(chk_errors)
	);

	bind sema_mem sema_properties u_props (
		.clk_i(clk_i), .reset_i(reset_i), .req_i(req_i), .cs_sema_i(cs_sema),
		.cs_config_i(cs_config_i), .ack_i(ack_o)
	);

	// ========================================
	// bus tasks
	// ========================================
	task automatic bus_access(input logic cfg, input logic we, input word_t adr,
			input word_t wdat, input logic want_ack);
		int waited;
		logic got;
		waited = 0;
		got = 1'b0;
		@(posedge clk);
		#1;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		req.we = we;
		req.sel = 4'hF;
		req.adr = adr;
		req.dat = wdat;
		cs_config = cfg;
		cs_io = ~cfg;
		while (!got && waited < ACK_TIMEOUT) begin
			@(posedge clk);
			#1;
			waited++;
			got = ack;
		end
		// config writes commit in the ack cycle, so hold through it
		if (got) begin
			@(posedge clk);
			#1;
		end
		// held strobe across the blanking cycle must not ack again
		if (got && hold_blank) begin
			@(posedge clk);
			#1;
		end
		req = '0;
		cs_config = 1'b0;
		cs_io = 1'b0;
		if (want_ack && !got) begin
			$display("no acknowledge received at %0t for address %08h", $time, adr);
			bus_errors++;
		end else if (!want_ack && got) begin
			$display("acknowledge at %0t for address %08h outside the open window", $time, adr);
			bus_errors++;
		end
	endtask

	function automatic word_t cfg_addr(input cfg_idx_t idx);
		return {4'h0, CFG_BUS, CFG_DEVICE, CFG_FUNC, 4'h0, idx, 2'b00};
	endfunction

	task automatic cfg_read(input cfg_idx_t idx, input word_t exp);
		cfg_exp = exp;
		bus_access(1'b1, 1'b0, cfg_addr(idx), '0, 1'b1);
	endtask

	task automatic cfg_write(input cfg_idx_t idx, input word_t wdat);
		bus_access(1'b1, 1'b1, cfg_addr(idx), wdat, 1'b1);
	endtask

	// op goes in dat[31:30], key in the low bits
	task automatic sema_write(input int slot, input logic [1:0] op, input logic [KEY_SIZE-1:0] key);
		bus_access(1'b0, 1'b1, sema_base | word_t'(slot << 2), {op, 14'd0, key}, 1'b1);
	endtask

	task automatic sema_read(input int slot);
		bus_access(1'b0, 1'b0, sema_base | word_t'(slot << 2), '0, 1'b1);
	endtask

	// access that must stay unanswered
	task automatic sema_probe(input logic we, input word_t adr);
		bus_access(1'b0, we, adr, 32'h0000BEEF, 1'b0);
	endtask

	// ========================================
	// sequences
	// ========================================
	initial begin
		int slot;
		int total;
		logic [1:0] op;
		logic [KEY_SIZE-1:0] key;
		word_t bar0_exp;
		reset = 1'b1;
		req = '0;
		cs_config = 1'b0;
		cs_io = 1'b0;
		cfg_exp = '0;
		hold_blank = 1'b0;
		sema_base = IO_ADDR & IO_ADDR_MASK;
		void'($urandom(32'h9184));
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		// identity, header and reset values
		cfg_read(6'd0, {DEVICE_ID, VENDOR_ID});
		cfg_read(6'd1, 32'h0);
		cfg_read(6'd2, {CLASS_CODE, SUBCLASS, PROGIF, REVISION});
		cfg_read(6'd3, 32'h0);
		cfg_read(6'd4, IO_ADDR);
		cfg_read(6'd5, 32'h0);
		cfg_read(6'd15, 32'h000000FF);

		// memory still disabled
		sema_probe(1'b1, sema_base | 32'h0C);
		sema_probe(1'b0, sema_base | 32'h0C);
		// only bits 0 to 2 of the command stick
		cfg_write(6'd1, 32'hFFFFFFFE);
		cfg_read(6'd1, 32'h00000006);

		// plain write round trips, both plain op codes
		for (int i = 0; i < 8; i++) begin
			sema_write(i, 2'(i % 2), 16'hA000 + 16'(i));
			sema_read(i);
		end
		sema_probe(1'b0, 32'h00000010);

		// move the window, old base must miss
		cfg_write(6'd4, 32'h12345678);
		bar0_exp = (IO_ADDR & ~IO_ADDR_MASK) | (32'h12345678 & IO_ADDR_MASK);
		cfg_read(6'd4, bar0_exp);
		sema_probe(1'b0, sema_base);
		sema_base = bar0_exp & IO_ADDR_MASK;
		sema_read(0);

		// lock, lock by another owner, wrong unlock, right unlock
		sema_write(20, 2'b10, 16'h1234);
		sema_read(20);
		sema_write(20, 2'b10, 16'h5678);
		sema_read(20);
		sema_write(20, 2'b11, 16'h5678);
		sema_read(20);
		sema_write(20, 2'b11, 16'h1234);
		sema_read(20);

		// few distinct keys so locks and unlocks collide often
		hold_blank = 1'b1;
		for (int i = 0; i < RANDOM_OPS; i++) begin
			slot = int'($urandom % NUM_SEMA);
			op = 2'($urandom % 4);
			key = KEY_SIZE'($urandom % 5) * 16'h1111;
			sema_write(slot, op, key);
			sema_read(slot);
		end
		hold_blank = 1'b0;

		repeat (4) @(posedge clk);
		#1;
		total = chk_errors + bus_errors + dut_i.u_mem.u_props.fail_total;
		$display("errors: checker %0d, bus %0d, assertions %0d", chk_errors, bus_errors,
			dut_i.u_mem.u_props.fail_total);
		if (total == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== tb/sema_checker.sv ====
// bus monitor with a reference key model for the semaphore bank
// samples on the falling edge, stimulus changes just after the rising edge
// config read data is compared with cfg_exp_i, set by the stimulus side
// semaphore slot is taken from adr[$clog2(NUM_SEMAPHORE)+1:2]
`timescale 1ns/1ps

module sema_checker import sema_pkg::*; #(
	parameter int NUM_SEMAPHORE = 64,
	parameter int KEY_SIZE = 16
) (
	input  logic     clk_i,
	input  logic     reset_i,
	input  bus_req_t req_i,
	input  logic     cs_config_i,
	input  logic     cs_io_i,
	input  logic     ack_i,
	input  word_t    dat_i,
	input  word_t    cfg_exp_i,
	output int       err_count_o
);

	localparam int ADDR_W = $clog2(NUM_SEMAPHORE);
	// edges from capture to the edge that raises ack
	localparam int READ_LAT = 3;
	localparam int WRITE_LAT = 5;

	// every slot starts unlocked
	logic [KEY_SIZE-1:0] model [NUM_SEMAPHORE] = '{default: '0};
	int errors = 0;
	int edge_cnt = 0;
	int start_edge = 0;
	logic busy = 1'b0;
	logic done = 1'b0;

	assign err_count_o = errors;

	// ========================================
	// reference rule for a semaphore write
	// ========================================
	function automatic logic [KEY_SIZE-1:0] next_key(input logic [1:0] op,
			input logic [KEY_SIZE-1:0] stored, input logic [KEY_SIZE-1:0] key);
		case (op)
			// lock, only into an empty slot
			2'b10: return (stored == '0) ? key : stored;
			// unlock, only by the holder of the key
			2'b11: return (stored == key) ? '0 : stored;
			default: return key;
		endcase
	endfunction

	task automatic report_value(input string name, input word_t exp, input word_t act);
		$display("CHECK FAILED time=%0t signal=%s expected=%08h actual=%08h", $time, name, exp, act);
		errors++;
	endtask

	always @(posedge clk_i) begin
		edge_cnt <= edge_cnt + 1;
	end

	// ========================================
	// access tracking and compare
	// ========================================
	always @(negedge clk_i) begin
		logic active;
		logic [ADDR_W-1:0] slot;
		int exp_lat;
		active = req_i.cyc & req_i.stb & (cs_config_i | cs_io_i);
		slot = req_i.adr[ADDR_W+1:2];
		exp_lat = req_i.we ? WRITE_LAT : READ_LAT;
		if (reset_i) begin
			busy = 1'b0;
			done = 1'b0;
		end else if (ack_i) begin
			if (!busy) begin
				$display("second acknowledge at %0t without a new access", $time);
				errors++;
			end else begin
				if (edge_cnt - start_edge != exp_lat) begin
					report_value("ack_o latency", exp_lat, edge_cnt - start_edge);
				end
				if (cs_config_i) begin
					if (!req_i.we && dat_i != cfg_exp_i) begin
						report_value("dat_o", cfg_exp_i, dat_i);
					end
				end else if (req_i.we) begin
					model[slot] = next_key(req_i.dat[31:30], model[slot], req_i.dat[KEY_SIZE-1:0]);
				end else if (dat_i != word_t'(model[slot])) begin
					report_value("dat_o", word_t'(model[slot]), dat_i);
				end
			end
			busy = 1'b0;
			done = 1'b1;
		end else if (!active) begin
			busy = 1'b0;
			done = 1'b0;
		end else if (!busy && !done) begin
			// DUT captures the request on the next rising edge
			busy = 1'b1;
			start_edge = edge_cnt + 1;
		end
	end

endmodule

// ==== tb/sema_properties.sv ====
// bus rule assertions, bound into sema_mem
// one access at a time is assumed, with an idle cycle between accesses
// each assertion keeps its own failure count for the testbench summary
`timescale 1ns/1ps

module sema_properties import sema_pkg::*; (
	input logic     clk_i,
	input logic     reset_i,
	input bus_req_t req_i,
	input logic     cs_sema_i,
	input logic     cs_config_i,
	input logic     ack_i
);

	// read request on either space
	logic rd_sel;
	int fail_single = 0;
	int fail_cyc = 0;
	int fail_rst = 0;
	int fail_lat = 0;
	int fail_total;

	assign rd_sel = (cs_sema_i | cs_config_i) & ~req_i.we;
	assign fail_total = fail_single + fail_cyc + fail_rst + fail_lat;

	// ========================================
	// ack shape
	// ========================================
	ack_single: assert property (@(posedge clk_i) disable iff (reset_i) ack_i |=> !ack_i)
		else begin
			$error("ack_o high in two consecutive cycles");
			fail_single++;
		end

	ack_needs_cyc: assert property (@(posedge clk_i) disable iff (reset_i) ack_i |-> req_i.cyc)
		else begin
			$error("ack_o high without cyc");
			fail_cyc++;
		end

	// no disable here, this one is about the reset itself
	ack_after_reset: assert property (@(posedge clk_i) reset_i |=> !ack_i)
		else begin
			$error("ack_o not low after reset");
			fail_rst++;
		end

	// captured on edge 0, raised by edge 3, sampled high on the 4th edge
	read_latency: assert property (@(posedge clk_i) disable iff (reset_i) $rose(rd_sel) |-> ##4 ack_i)
		else begin
			$error("read ack not 3 cycles after the request");
			fail_lat++;
		end

endmodule

// ==== verilog/sema_top.sv ====
// semaphore bank with config space on a 32-bit cyc/stb/ack bus
// no interrupts, no byte-lane writes
// memory window stays closed until command bit 1 is set
`timescale 1ns/1ps

module sema_top import sema_pkg::*; #(
	parameter int          NUM_SEMAPHORE = 2048,
	parameter int          KEY_SIZE = 16,
	parameter word_t       IO_ADDR = 32'hFEE80001,
	parameter word_t       IO_ADDR_MASK = 32'h00FC0000,
	parameter logic [7:0]  CFG_BUS = 8'd0,
	parameter logic [4:0]  CFG_DEVICE = 5'd17,
	parameter logic [2:0]  CFG_FUNC = 3'd0,
	parameter logic [15:0] CFG_VENDOR_ID = 16'h0000,
	parameter logic [15:0] CFG_DEVICE_ID = 16'h0017,
	// memory controller, other
	parameter logic [7:0]  CFG_CLASS = 8'h05,
	parameter logic [7:0]  CFG_SUBCLASS = 8'h80,
	parameter logic [7:0]  CFG_REVISION_ID = 8'h00
) (
	input  logic     clk_i,
	input  logic     reset_i,
	input  logic     cs_config_i,
	input  logic     cs_io_i,
	input  bus_req_t req_i,
	output logic     ack_o,
	output word_t    dat_o
);

	// qualified config select
	logic cs_config;
	logic bar0_hit;
	logic cfg_ack;
	word_t cfg_dat;

	// ========================================
	// config space and BAR0 decode
	// ========================================
	sema_config #(
		.IO_ADDR(IO_ADDR),
		.IO_ADDR_MASK(IO_ADDR_MASK),
		.CFG_BUS(CFG_BUS),
		.CFG_DEVICE(CFG_DEVICE),
		.CFG_FUNC(CFG_FUNC),
		.CFG_VENDOR_ID(CFG_VENDOR_ID),
		.CFG_DEVICE_ID(CFG_DEVICE_ID),
		.CFG_CLASS(CFG_CLASS),
		.CFG_SUBCLASS(CFG_SUBCLASS),
		.CFG_REVISION_ID(CFG_REVISION_ID)
	) u_config (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.req_i(req_i),
		.cs_config_i(cs_config_i),
		.cfg_ack_i(cfg_ack),
		.cs_config_o(cs_config),
		.cfg_dat_o(cfg_dat),
		.bar0_hit_o(bar0_hit)
	);

	// semaphore core, acks both spaces
	sema_mem #(
		.NUM_SEMAPHORE(NUM_SEMAPHORE),
		.KEY_SIZE(KEY_SIZE)
	) u_mem (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.req_i(req_i),
		.cs_io_i(cs_io_i),
		.cs_config_i(cs_config),
		.bar0_hit_i(bar0_hit),
		.cfg_dat_i(cfg_dat),
		.ack_o(ack_o),
		.cfg_ack_o(cfg_ack),
		.dat_o(dat_o)
	);

endmodule

// ==== verilog/sema_mem.sv ====
// semaphore core, owns the ack for config and semaphore accesses
// one access at a time, master holds the request until ack_o
// KEY_SIZE at most 30, dat[31:30] carries the op
// slot index is adr[$clog2(NUM_SEMAPHORE)+1:2], higher bits ignored
// a lock does not report success, software reads the slot back
`timescale 1ns/1ps

module sema_mem import sema_pkg::*; #(
	parameter int NUM_SEMAPHORE = 2048,
	parameter int KEY_SIZE = 16
) (
	input  logic     clk_i,
	input  logic     reset_i,
	input  bus_req_t req_i,
	input  logic     cs_io_i,
	input  logic     cs_config_i,
	input  logic     bar0_hit_i,
	input  word_t    cfg_dat_i,
	output logic     ack_o,
	output logic     cfg_ack_o,
	output word_t    dat_o
);

	localparam int ADDR_W = $clog2(NUM_SEMAPHORE);

	bus_req_t req_q;
	logic cs_sema;
	logic sema_sel_q;
	logic cfg_sel_q;
	logic any_sel;
	logic key_wr;
	logic [ADDR_W-1:0] slot;
	logic [KEY_SIZE-1:0] stored_key;
	logic [KEY_SIZE-1:0] wr_key;
	logic [KEY_SIZE-1:0] new_key;
	sema_op_e op;

	// semaphore window select
	assign cs_sema = cs_io_i & req_i.cyc & req_i.stb & bar0_hit_i;

	// ========================================
	// request capture
	// ========================================
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			sema_sel_q <= 1'b0;
			cfg_sel_q <= 1'b0;
		end else begin
			sema_sel_q <= cs_sema;
			cfg_sel_q <= cs_config_i;
		end
	end

	// sel rides along but only gets latched
	always_ff @(posedge clk_i) begin
		req_q <= req_i;
	end

	assign any_sel = sema_sel_q | cfg_sel_q;
	assign slot = req_q.adr[ADDR_W+1:2];
	assign op = sema_op_e'(req_q.dat[31:30]);
	assign wr_key = req_q.dat[KEY_SIZE-1:0];

	// ========================================
	// key update rule
	// ========================================
	always_comb begin
		case (op)
			// only an empty slot takes the key
			OP_LOCK:   new_key = (stored_key == '0) ? wr_key : stored_key;
			// owner clears, anyone else leaves it alone
			OP_UNLOCK: new_key = (stored_key == wr_key) ? '0 : stored_key;
			default:   new_key = wr_key;
		endcase
	end

	// stored key settles two edges after capture, well before the write ack
	assign key_wr = sema_sel_q & req_q.we & ack_o;
	// lets the config block commit its write once
	assign cfg_ack_o = cfg_sel_q & ack_o;

	// read ack 2 stages + out reg, write ack 4 stages + out reg
	sema_ack_gen #(
		.READ_STAGES(2),
		.WRITE_STAGES(4)
	) u_ack_gen (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.rd_req_i(any_sel & ~req_q.we),
		.wr_req_i(any_sel & req_q.we),
		.ack_o(ack_o)
	);

	// read and write share the latched slot
	sema_key_ram #(
		.NUM_SEMAPHORE(NUM_SEMAPHORE),
		.KEY_SIZE(KEY_SIZE)
	) u_key_ram (
		.clk_i(clk_i),
		.wr_en_i(key_wr),
		.wr_addr_i(slot),
		.wr_key_i(new_key),
		.rd_en_i(sema_sel_q),
		.rd_addr_i(slot),
		.rd_key_o(stored_key)
	);

	// read data, config takes priority
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			dat_o <= '0;
		end else if (cfg_sel_q) begin
			dat_o <= cfg_dat_i;
		end else if (sema_sel_q) begin
			dat_o <= word_t'(stored_key);
		end else begin
			dat_o <= '0;
		end
	end

endmodule

// ==== verilog/sema_config.sv ====
// PCI-style type 0 config header for the semaphore bank
// only BAR0 decodes, BAR1/BAR2/expansion ROM read as zero
// config writes commit on cfg_ack_i, byte selects are ignored
// master must hold adr/dat through the ack cycle
// BAR0 bits outside IO_ADDR_MASK keep their IO_ADDR value
`timescale 1ns/1ps

module sema_config import sema_pkg::*; #(
	parameter word_t       IO_ADDR = 32'hFEE80001,
	parameter word_t       IO_ADDR_MASK = 32'h00FC0000,
	parameter logic [7:0]  CFG_BUS = 8'd0,
	parameter logic [4:0]  CFG_DEVICE = 5'd17,
	parameter logic [2:0]  CFG_FUNC = 3'd0,
	parameter logic [15:0] CFG_VENDOR_ID = 16'h0000,
	parameter logic [15:0] CFG_DEVICE_ID = 16'h0017,
	parameter logic [7:0]  CFG_CLASS = 8'h05,
	parameter logic [7:0]  CFG_SUBCLASS = 8'h80,
	parameter logic [7:0]  CFG_REVISION_ID = 8'h00
) (
	input  logic     clk_i,
	input  logic     reset_i,
	input  bus_req_t req_i,
	input  logic     cs_config_i,
	input  logic     cfg_ack_i,
	output logic     cs_config_o,
	output word_t    cfg_dat_o,
	output logic     bar0_hit_o
);

	// fixed header fields
	localparam logic [7:0] CFG_PROGIF = 8'h01;
	localparam logic [7:0] CFG_HEADER_TYPE = 8'h00;
	localparam logic [7:0] CFG_IRQ_LINE = 8'hFF;

	// dword map
	localparam cfg_idx_t IDX_ID = 6'd0;
	localparam cfg_idx_t IDX_CMD = 6'd1;
	localparam cfg_idx_t IDX_CLASS = 6'd2;
	localparam cfg_idx_t IDX_HDR = 6'd3;
	localparam cfg_idx_t IDX_BAR0 = 6'd4;
	localparam cfg_idx_t IDX_IRQ = 6'd15;

	cfg_idx_t idx;
	// bit 0 io, bit 1 memory enable, bit 2 bus master
	logic [2:0] cmd;
	word_t bar0;
	logic cfg_wr;

	assign idx = req_i.adr[7:2];

	// bus / device / function match on adr[27:12]
	assign cs_config_o = cs_config_i & req_i.cyc & req_i.stb &
		(req_i.adr[27:20] == CFG_BUS) &
		(req_i.adr[19:15] == CFG_DEVICE) &
		(req_i.adr[14:12] == CFG_FUNC);

	// window compare against the live BAR0
	assign bar0_hit_o = cmd[1] & ((req_i.adr & IO_ADDR_MASK) == (bar0 & IO_ADDR_MASK));

	// one commit per access, ack is a single cycle
	assign cfg_wr = cfg_ack_i & cs_config_o & req_i.we;

	// ========================================
	// writable registers
	// ========================================
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			cmd <= 3'b000;
			bar0 <= IO_ADDR;
		end else if (cfg_wr) begin
			if (idx == IDX_CMD) begin
				cmd <= req_i.dat[2:0];
			end
			if (idx == IDX_BAR0) begin
				// only the size-mask bits move
				bar0 <= (bar0 & ~IO_ADDR_MASK) | (req_i.dat & IO_ADDR_MASK);
			end
		end
	end

	// read mux, registered
	always_ff @(posedge clk_i) begin
		case (idx)
			IDX_ID:    cfg_dat_o <= {CFG_DEVICE_ID, CFG_VENDOR_ID};
			// status half reads as zero
			IDX_CMD:   cfg_dat_o <= {16'h0000, 13'd0, cmd};
			IDX_CLASS: cfg_dat_o <= {CFG_CLASS, CFG_SUBCLASS, CFG_PROGIF, CFG_REVISION_ID};
			IDX_HDR:   cfg_dat_o <= {8'h00, CFG_HEADER_TYPE, 16'h0000};
			IDX_BAR0:  cfg_dat_o <= bar0;
			// interrupt pin 0, line unassigned
			IDX_IRQ:   cfg_dat_o <= {16'h0000, 8'h00, CFG_IRQ_LINE};
			default:   cfg_dat_o <= '0;
		endcase
	end

endmodule

// ==== verilog/sema_key_ram.sv ====
// behavioral simple dual-port key storage, one clock
// read path has two registers, both held while rd_en_i is low
// a read and a write to the same slot on one edge returns the old key
// contents start at zero, there is no reset of the array
`timescale 1ns/1ps

module sema_key_ram #(
	parameter int NUM_SEMAPHORE = 2048,
	parameter int KEY_SIZE = 16
) (
	input  logic                             clk_i,
	input  logic                             wr_en_i,
	input  logic [$clog2(NUM_SEMAPHORE)-1:0] wr_addr_i,
	input  logic [KEY_SIZE-1:0]              wr_key_i,
	input  logic                             rd_en_i,
	input  logic [$clog2(NUM_SEMAPHORE)-1:0] rd_addr_i,
	output logic [KEY_SIZE-1:0]              rd_key_o
);

	// every slot unlocked at power up
	logic [KEY_SIZE-1:0] mem [NUM_SEMAPHORE] = '{default: '0};

	// first read register, array output
	logic [KEY_SIZE-1:0] rd_stage;

	// write port
	always_ff @(posedge clk_i) begin
		if (wr_en_i) begin
			mem[wr_addr_i] <= wr_key_i;
		end
	end

	// ========================================
	// read port, two cycles of latency
	// ========================================
	always_ff @(posedge clk_i) begin
		if (rd_en_i) begin
			rd_stage <= mem[rd_addr_i];
			// output register, like a block RAM doutb reg
			rd_key_o <= rd_stage;
		end
	end

endmodule

// ==== verilog/sema_ack_gen.sv ====
// acknowledge generator for one outstanding access at a time
// rd_req_i and wr_req_i are levels that must stay high until ack_o
// both stage counts must be at least 1
// a request dropped early flushes its pipeline and gets no ack
`timescale 1ns/1ps

module sema_ack_gen #(
	parameter int READ_STAGES = 2,
	parameter int WRITE_STAGES = 4
) (
	input  logic clk_i,
	input  logic reset_i,
	input  logic rd_req_i,
	input  logic wr_req_i,
	output logic ack_o
);

	// wait for a full pipe, ack one cycle, then blank one cycle
	typedef enum logic [1:0] {
		ST_WAIT,
		ST_ACK,
		ST_BLANK
	} ack_state_e;

	ack_state_e state;
	logic [READ_STAGES-1:0] rd_pipe;
	logic [WRITE_STAGES-1:0] wr_pipe;
	logic pipe_done;

	// last stage reached with the request still held
	assign pipe_done = (rd_pipe[READ_STAGES-1] & rd_req_i) |
		(wr_pipe[WRITE_STAGES-1] & wr_req_i);

	// shift a one in per cycle, drop everything when the request falls
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			rd_pipe <= '0;
			wr_pipe <= '0;
		end else if (state != ST_WAIT) begin
			// held strobe must start over after the ack
			rd_pipe <= '0;
			wr_pipe <= '0;
		end else begin
			rd_pipe <= ((rd_pipe << 1) | READ_STAGES'(1)) & {READ_STAGES{rd_req_i}};
			wr_pipe <= ((wr_pipe << 1) | WRITE_STAGES'(1)) & {WRITE_STAGES{wr_req_i}};
		end
	end

	// ========================================
	// ack output register
	// ========================================
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state <= ST_WAIT;
			ack_o <= 1'b0;
		end else begin
			case (state)
				ST_WAIT: begin
					if (pipe_done) begin
						state <= ST_ACK;
						ack_o <= 1'b1;
					end
				end
				ST_ACK: begin
					state <= ST_BLANK;
					ack_o <= 1'b0;
				end
				// registered select still shows the old strobe here
				default: state <= ST_WAIT;
			endcase
		end
	end

endmodule

// ==== verilog/sema_pkg.sv ====
// shared types for the semaphore bank
// bus is 32 bits wide with cyc/stb/ack only, no bursts, no tags
// op code always sits in dat[31:30], so keys are limited to 30 bits
package sema_pkg;

	// ========================================
	// bus words
	// ========================================

	// data or address word
	typedef logic [31:0] word_t;

	// byte lane select, carried but not acted on
	typedef logic [3:0] sel_t;

	// one request as driven by the master
	typedef struct packed {
		logic  cyc;
		logic  stb;
		logic  we;
		sel_t  sel;
		word_t adr;
		word_t dat;
	} bus_req_t;

	// ========================================
	// semaphore and config encodings
	// ========================================

	// write op taken from dat[31:30]
	typedef enum logic [1:0] {
		OP_WRITE0 = 2'b00,
		OP_WRITE1 = 2'b01,
		// store only into an empty slot
		OP_LOCK   = 2'b10,
		// clear only on a key match
		OP_UNLOCK = 2'b11
	} sema_op_e;

	// config dword index, adr[7:2]
	typedef logic [5:0] cfg_idx_t;

endpackage
